/* design/core_mem_pkg.sv */
// shared types for the memory stages, data memory and testbench; import with core_mem_pkg::*
package core_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // where the destination value comes from
    typedef enum logic [1:0] {
        RD_SRC_ALU = 2'd0,
        RD_SRC_CSR = 2'd1,
        RD_SRC_MEM = 2'd2
    } rd_src_e;

    typedef enum logic [1:0] {
        MEM_OP_NOP   = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    // execute result entering memory-1
    typedef struct packed {
        word_t     pc;
        rd_src_e   rd_src;
        reg_idx_t  rd_idx;
        logic      rd_we;
        word_t     alu_result;     // also the load/store address
        word_t     csr_old_val;
        mem_op_e   mem_op;
        logic      mem_signed;
        mem_size_e mem_size;
        word_t     rs2_val;        // store data
        logic      branch_taken;
        word_t     branch_target;
    } e_to_m1_s;

    typedef struct packed {
        word_t     pc;
        rd_src_e   rd_src;
        reg_idx_t  rd_idx;
        logic      rd_we;
        word_t     alu_result;
        word_t     csr_old_val;
        mem_op_e   mem_op;
        logic      mem_signed;
        mem_size_e mem_size;
        word_t     rs2_val;
    } m1_to_m2_s;

    typedef struct packed {
        logic     rd_we;
        reg_idx_t rd_idx;
        word_t    val;
        logic     val_avail;       // val is already final
    } fwd_s;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd_idx;
        logic     rd_we;
        word_t    rd_val;
    } wb_s;

    // one read word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage

/* design/data_mem.sv */
// byte-writable synchronous data memory behind the dmem_if port, registered read with write bypass
`timescale 1ns/1ps

module data_mem
    import core_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic   clk,
    input  logic   rst_n,
    dmem_if.memory dmem
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    logic [3:0][7:0]   mem [DMEM_WORDS];
    logic [ADDR_W-1:0] ridx;
    logic [ADDR_W-1:0] widx_q;   // address of the item now in memory-1
    word_t             rd_next;
    word_t             rdata_q;

    assign ridx = dmem.addr[ADDR_W+1:2];

    // the store leaving memory-1 was addressed when that item was accepted
    always_ff @(posedge clk) begin
        if (!dmem.stall) begin
            widx_q <= ridx;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem.wstrb[i]) begin
                mem[widx_q][i] <= dmem.wdata[i*8 +: 8];
            end
        end
    end

    // same-word bypass so a load right behind a store sees the new bytes
    always_comb begin
        rd_next = mem[ridx];
        for (int i = 0; i < 4; i++) begin
            if (dmem.wstrb[i] && (widx_q == ridx)) begin
                rd_next[i*8 +: 8] = dmem.wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (!dmem.stall) begin
            rdata_q <= rd_next;
        end
    end

    assign dmem.rdata = rdata_q;

endmodule

/* design/dmem_if.sv */
// single-cycle data memory port shared by both memory stages and the data memory
`timescale 1ns/1ps

interface dmem_if
    import core_mem_pkg::*;
(
    input logic stall
);

    word_t       addr;    // read address of the item being accepted
    logic [3:0]  wstrb;   // nonzero only while a store leaves memory-1
    word_t       wdata;   // store data replicated over the byte lanes
    word_t       rdata;

    // memory-1 side
    modport requester (
        output addr,
        output wstrb,
        output wdata
    );

    // memory-2 side
    modport reader (
        input rdata
    );

    modport memory (
        input  stall,
        input  addr,
        input  wstrb,
        input  wdata,
        output rdata
    );

endinterface

/* design/mem_pipe_top.sv */
// top of the memory half of the pipeline: both memory stages and the data memory
`timescale 1ns/1ps

module mem_pipe_top
    import core_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     stall,
    input  logic     flush,
    output logic     m1_ready,

    input  logic     e_to_m1_valid,
    input  e_to_m1_s e_to_m1,

    output logic     branch_taken,
    output word_t    branch_target,

    output fwd_s     fwd_m1,
    output fwd_s     fwd_m2,

    output logic     wb_valid,
    output wb_s      wb
);

    logic      m1_to_m2_valid;
    m1_to_m2_s m1_to_m2;

    dmem_if u_dmem_if (
        .stall (stall)
    );

    stage_memory1 u_stage_memory1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .stall          (stall),
        .m1_ready       (m1_ready),
        .e_to_m1_valid  (e_to_m1_valid),
        .e_to_m1        (e_to_m1),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .fwd            (fwd_m1),
        .dmem           (u_dmem_if.requester)
    );

    stage_memory2 u_stage_memory2 (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .fwd            (fwd_m2),
        .dmem           (u_dmem_if.reader)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .dmem  (u_dmem_if.memory)
    );

endmodule

/* design/stage_memory1.sv */
// memory-1 pipeline stage: registers the execute result, issues address and store, reports branches
`timescale 1ns/1ps

module stage_memory1
    import core_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      flush,
    input  logic      stall,
    output logic      m1_ready,

    input  logic      e_to_m1_valid,
    input  e_to_m1_s  e_to_m1,

    output logic      branch_taken,
    output word_t     branch_target,

    output logic      m1_to_m2_valid,
    output m1_to_m2_s m1_to_m2,
    output fwd_s      fwd,

    dmem_if.requester dmem
);

    logic       in_valid_q;
    e_to_m1_s   in_q;
    logic       leaving;
    logic [3:0] strb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
        end else if (!stall) begin
            in_valid_q <= e_to_m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            in_q <= e_to_m1;
        end
    end

    assign m1_ready = 1'b1;   // fixed memory latency
    assign leaving  = in_valid_q && !flush && !stall;

    // read issued for the incoming item, data is ready when it reaches memory-2
    assign dmem.addr = e_to_m1.alu_result;

    always_comb begin
        case (in_q.mem_size)
            MEM_SIZE_BYTE: strb = 4'b0001 << in_q.alu_result[1:0];
            MEM_SIZE_HALF: strb = 4'b0011 << {in_q.alu_result[1], 1'b0};
            default:       strb = 4'b1111;
        endcase
    end

    assign dmem.wstrb = (leaving && in_q.mem_op == MEM_OP_STORE) ? strb : 4'b0000;
    assign dmem.wdata = (in_q.mem_size == MEM_SIZE_BYTE) ? {4{in_q.rs2_val[7:0]}} :
                        (in_q.mem_size == MEM_SIZE_HALF) ? {2{in_q.rs2_val[15:0]}} :
                        in_q.rs2_val;

    assign branch_taken  = in_valid_q && !flush && in_q.branch_taken;
    assign branch_target = in_q.branch_target;

    always_comb begin
        fwd.rd_we     = in_valid_q && !flush && in_q.rd_we;
        fwd.rd_idx    = in_q.rd_idx;
        fwd.val_avail = (in_q.mem_op != MEM_OP_LOAD);   // load data arrives in memory-2
        case (in_q.rd_src)
            RD_SRC_ALU: fwd.val = in_q.alu_result;
            RD_SRC_CSR: fwd.val = in_q.csr_old_val;
            default:    fwd.val = '0;
        endcase
    end

    assign m1_to_m2_valid = leaving;
    assign m1_to_m2 = '{
        pc:          in_q.pc,
        rd_src:      in_q.rd_src,
        rd_idx:      in_q.rd_idx,
        rd_we:       in_q.rd_we,
        alu_result:  in_q.alu_result,
        csr_old_val: in_q.csr_old_val,
        mem_op:      in_q.mem_op,
        mem_signed:  in_q.mem_signed,
        mem_size:    in_q.mem_size,
        rs2_val:     in_q.rs2_val
    };

    // strobes only cover one word, a misaligned store would land in the wrong lanes
    a_store_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_valid_q && in_q.mem_op == MEM_OP_STORE) |->
            ((in_q.mem_size != MEM_SIZE_HALF || !in_q.alu_result[0]) &&
             (in_q.mem_size != MEM_SIZE_WORD || in_q.alu_result[1:0] == 2'b00))
    );

endmodule

/* design/stage_memory2.sv */
// memory-2 pipeline stage: aligns and extends load data, picks the destination value for writeback
`timescale 1ns/1ps

module stage_memory2
    import core_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      stall,

    input  logic      m1_to_m2_valid,
    input  m1_to_m2_s m1_to_m2,

    output logic      wb_valid,
    output wb_s       wb,
    output fwd_s      fwd,

    dmem_if.reader    dmem
);

    logic       valid_q;
    m1_to_m2_s  item_q;
    load_word_u lword_q;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t      load_val;
    word_t      rd_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= m1_to_m2_valid;
        end
    end

    // read word was registered in data memory when memory-1 took the item
    always_ff @(posedge clk) begin
        if (!stall) begin
            item_q  <= m1_to_m2;
            lword_q <= dmem.rdata;
        end
    end

    assign sel_byte = lword_q.bytes[item_q.alu_result[1:0]];
    assign sel_half = lword_q.halves[item_q.alu_result[1]];

    always_comb begin
        case (item_q.mem_size)
            MEM_SIZE_BYTE: begin
                if (item_q.mem_signed) begin
                    load_val = {{24{sel_byte[7]}}, sel_byte};
                end else begin
                    load_val = {24'h000000, sel_byte};
                end
            end
            MEM_SIZE_HALF: begin
                if (item_q.mem_signed) begin
                    load_val = {{16{sel_half[15]}}, sel_half};
                end else begin
                    load_val = {16'h0000, sel_half};
                end
            end
            default: load_val = lword_q;   // full word, no extension
        endcase
    end

    always_comb begin
        case (item_q.rd_src)
            RD_SRC_CSR: rd_val = item_q.csr_old_val;
            RD_SRC_MEM: rd_val = load_val;
            default:    rd_val = item_q.alu_result;
        endcase
    end

    // held item stays on the outputs under stall
    assign wb_valid = valid_q;
    assign wb = '{
        pc:     item_q.pc,
        rd_idx: item_q.rd_idx,
        rd_we:  item_q.rd_we,
        rd_val: rd_val
    };

    assign fwd.rd_we     = valid_q && item_q.rd_we;
    assign fwd.rd_idx    = item_q.rd_idx;
    assign fwd.val       = rd_val;
    assign fwd.val_avail = valid_q;

    // execute must not send misaligned loads, nothing here splits an access
    a_load_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_q && item_q.mem_op == MEM_OP_LOAD) |->
            ((item_q.mem_size != MEM_SIZE_HALF || !item_q.alu_result[0]) &&
             (item_q.mem_size != MEM_SIZE_WORD || item_q.alu_result[1:0] == 2'b00))
    );

endmodule

/* tb/mem_pipe_tests.svh */
// directed tests and the reference memory model, included inside the tb_mem_pipe module
`ifndef MEM_PIPE_TESTS_SVH
`define MEM_PIPE_TESTS_SVH

    word_t ref_mem [DMEM_WORDS];   // expected data memory contents
    word_t next_pc = 32'h0000_1000;

    function automatic word_t new_pc();
        next_pc += 4;
        return next_pc;
    endfunction

    function automatic int word_index(word_t addr);
        return (addr >> 2) % DMEM_WORDS;
    endfunction

    function automatic e_to_m1_s base_item(word_t pc);
        e_to_m1_s it;
        it          = '0;
        it.pc       = pc;
        it.rd_src   = RD_SRC_ALU;
        it.mem_op   = MEM_OP_NOP;
        it.mem_size = MEM_SIZE_WORD;
        return it;
    endfunction

    function automatic e_to_m1_s alu_item(rd_src_e src, reg_idx_t rd, word_t alu, word_t csr);
        e_to_m1_s it;
        it             = base_item(new_pc());
        it.rd_src      = src;
        it.rd_idx      = rd;
        it.rd_we       = 1'b1;
        it.alu_result  = alu;
        it.csr_old_val = csr;
        return it;
    endfunction

    function automatic e_to_m1_s load_item(word_t addr, mem_size_e size, logic sgn, reg_idx_t rd);
        e_to_m1_s it;
        it            = base_item(new_pc());
        it.rd_src     = RD_SRC_MEM;
        it.rd_idx     = rd;
        it.rd_we      = 1'b1;
        it.alu_result = addr;
        it.mem_op     = MEM_OP_LOAD;
        it.mem_signed = sgn;
        it.mem_size   = size;
        return it;
    endfunction

    function automatic e_to_m1_s store_item(word_t addr, mem_size_e size, word_t data);
        e_to_m1_s it;
        it            = base_item(new_pc());
        it.alu_result = addr;
        it.mem_op     = MEM_OP_STORE;
        it.mem_size   = size;
        it.rs2_val    = data;
        return it;
    endfunction

    function automatic fwd_s make_fwd(logic we, reg_idx_t idx, word_t val, logic avail);
        fwd_s f;
        f.rd_we     = we;
        f.rd_idx    = idx;
        f.val       = val;
        f.val_avail = avail;
        return f;
    endfunction

    function automatic void model_store(word_t addr, mem_size_e size, word_t data);
        int idx;
        int lane;
        idx  = word_index(addr);
        lane = addr[1:0];
        case (size)
            MEM_SIZE_BYTE: ref_mem[idx][lane*8 +: 8]  = data[7:0];
            MEM_SIZE_HALF: ref_mem[idx][lane*8 +: 16] = data[15:0];
            default:       ref_mem[idx] = data;
        endcase
    endfunction

    // shift the addressed lane down, then extend by size and signedness
    function automatic word_t model_load(word_t addr, mem_size_e size, logic sgn);
        word_t w;
        word_t v;
        w = ref_mem[word_index(addr)] >> (8 * addr[1:0]);
        case (size)
            MEM_SIZE_BYTE: v = sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            MEM_SIZE_HALF: v = sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default:       v = w;
        endcase
        return v;
    endfunction

    function automatic wb_s expected_wb(e_to_m1_s it);
        wb_s exp;
        exp.pc     = it.pc;
        exp.rd_idx = it.rd_idx;
        exp.rd_we  = it.rd_we;
        case (it.rd_src)
            RD_SRC_CSR: exp.rd_val = it.csr_old_val;
            RD_SRC_MEM: exp.rd_val = model_load(it.alu_result, it.mem_size, it.mem_signed);
            default:    exp.rd_val = it.alu_result;
        endcase
        return exp;
    endfunction

    task automatic run_item(input string name, input e_to_m1_s it);
        wb_s exp;
        exp = expected_wb(it);
        if (it.mem_op == MEM_OP_STORE) begin
            model_store(it.alu_result, it.mem_size, it.rs2_val);
        end
        send_item(it);
        idle_input();
        wait_wb(name, it.pc);
        check_wb(name, exp, wb);
    endtask

    task automatic test_alu_csr_wb();
        @(negedge clk);
        check_flag("reset_wb_valid", 1'b0, wb_valid);
        check_flag("reset_m1_ready", 1'b1, m1_ready);
        check_branch("reset_branch", 1'b0, '0, branch_taken, branch_target);
        run_item("alu_wb", alu_item(RD_SRC_ALU, 5'd3, $urandom(), $urandom()));
        run_item("csr_wb", alu_item(RD_SRC_CSR, 5'd7, $urandom(), $urandom()));
    endtask

    task automatic test_store_load();
        word_t base;
        word_t data;
        base = 32'h0000_0100;
        for (int w = 0; w < 4; w++) begin
            data = $urandom();
            if (w == 0) data |= 32'h8080_8080;   // every lane negative
            if (w == 1) data &= 32'h7F7F_7F7F;   // every lane positive
            run_item("store_word", store_item(base + 4 * w, MEM_SIZE_WORD, data));
        end
        run_item("store_byte", store_item(base + 1, MEM_SIZE_BYTE, $urandom()));
        run_item("store_half", store_item(base + 6, MEM_SIZE_HALF, $urandom()));
        for (int w = 0; w < 4; w++) begin
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++) begin
                    run_item("load_byte",
                             load_item(base + 4 * w + off, MEM_SIZE_BYTE, s[0], 5'd10));
                end
                for (int off = 0; off < 4; off += 2) begin
                    run_item("load_half",
                             load_item(base + 4 * w + off, MEM_SIZE_HALF, s[0], 5'd11));
                end
                run_item("load_word", load_item(base + 4 * w, MEM_SIZE_WORD, s[0], 5'd12));
            end
        end
    endtask

    // load accepted on the edge that writes the store
    task automatic store_then_load(input string name, input e_to_m1_s st, input e_to_m1_s ld);
        wb_s exp_st;
        wb_s exp_ld;
        exp_st = expected_wb(st);
        model_store(st.alu_result, st.mem_size, st.rs2_val);
        exp_ld = expected_wb(ld);
        send_item(st);
        send_item(ld);
        idle_input();
        wait_wb(name, st.pc);
        check_wb(name, exp_st, wb);
        wait_wb(name, ld.pc);
        check_wb(name, exp_ld, wb);
    endtask

    task automatic test_store_load_bypass();
        run_item("bypass_init", store_item(32'h0000_0200, MEM_SIZE_WORD, $urandom()));
        store_then_load("bypass_half", store_item(32'h0000_0202, MEM_SIZE_HALF, $urandom()),
                        load_item(32'h0000_0200, MEM_SIZE_WORD, 1'b0, 5'd13));
        store_then_load("bypass_byte", store_item(32'h0000_0201, MEM_SIZE_BYTE, $urandom()),
                        load_item(32'h0000_0201, MEM_SIZE_BYTE, 1'b1, 5'd14));
    endtask

    task automatic test_stall_flush();
        e_to_m1_s first;
        e_to_m1_s second;
        e_to_m1_s st;
        wb_s      exp_first;
        first     = alu_item(RD_SRC_ALU, 5'd4, $urandom(), $urandom());
        second    = alu_item(RD_SRC_CSR, 5'd5, $urandom(), $urandom());
        exp_first = expected_wb(first);
        send_item(first);
        send_item(second);
        @(posedge clk);
        e_to_m1_valid <= 1'b0;
        stall         <= 1'b1;   // first in memory-2, second held in memory-1
        wait_wb("stall_first", first.pc);
        repeat (3) begin
            @(negedge clk);
            check_flag("stall_wb_valid", 1'b1, wb_valid);
            check_wb("stall_hold", exp_first, wb);
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_wb("stall_second", second.pc);
        check_wb("stall_second", expected_wb(second), wb);

        // flushed store with a taken branch, memory must keep the old word
        st = store_item(32'h0000_0104, MEM_SIZE_WORD, ~ref_mem[word_index(32'h0000_0104)]);
        st.branch_taken  = 1'b1;
        st.branch_target = 32'h0000_0400;
        send_item(st);
        @(posedge clk);
        e_to_m1_valid <= 1'b0;
        flush         <= 1'b1;
        @(negedge clk);
        check_branch("flush_branch", 1'b0, '0, branch_taken, branch_target);
        @(posedge clk);
        flush <= 1'b0;
        expect_no_wb("flush_no_wb", 4);
        run_item("flush_check", load_item(32'h0000_0104, MEM_SIZE_WORD, 1'b0, 5'd6));
    endtask

    task automatic test_branch_fwd();
        e_to_m1_s br;
        e_to_m1_s ld;
        wb_s      exp;
        br = alu_item(RD_SRC_ALU, 5'd8, $urandom(), $urandom());
        br.branch_taken  = 1'b1;
        br.branch_target = $urandom() & 32'hFFFF_FFFC;
        exp = expected_wb(br);
        send_item(br);
        idle_input();
        @(negedge clk);   // item sits in memory-1
        check_branch("branch_m1", 1'b1, br.branch_target, branch_taken, branch_target);
        check_fwd("fwd_m1_alu", make_fwd(1'b1, br.rd_idx, br.alu_result, 1'b1), fwd_m1);
        wait_wb("branch_wb", br.pc);
        check_wb("branch_wb", exp, wb);
        check_fwd("fwd_m2_alu", make_fwd(1'b1, exp.rd_idx, exp.rd_val, 1'b1), fwd_m2);

        ld  = load_item(32'h0000_0108, MEM_SIZE_HALF, 1'b1, 5'd9);
        exp = expected_wb(ld);
        send_item(ld);
        idle_input();
        @(negedge clk);
        check_branch("branch_none", 1'b0, '0, branch_taken, branch_target);
        check_fwd("fwd_m1_load", make_fwd(1'b1, ld.rd_idx, '0, 1'b0), fwd_m1);
        wait_wb("load_fwd_wb", ld.pc);
        check_wb("load_fwd_wb", exp, wb);
        check_fwd("fwd_m2_load", make_fwd(1'b1, ld.rd_idx, exp.rd_val, 1'b1), fwd_m2);
    endtask

`endif

/* tb/tb_mem_pipe.sv */
// testbench top that drives mem_pipe_top through the directed tests and reports the result
`timescale 1ns/1ps

module tb_mem_pipe
    import core_mem_pkg::*;
();

    localparam int DMEM_WORDS = 256;
    localparam int WAIT_LIMIT = 20;   // cycles allowed for any single wait

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     flush;
    logic     e_to_m1_valid;
    e_to_m1_s e_to_m1;
    logic     m1_ready;
    logic     branch_taken;
    word_t    branch_target;
    fwd_s     fwd_m1;
    fwd_s     fwd_m2;
    logic     wb_valid;
    wb_s      wb;
    int       errors;

    mem_pipe_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .m1_ready      (m1_ready),
        .e_to_m1_valid (e_to_m1_valid),
        .e_to_m1       (e_to_m1),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fwd_m1        (fwd_m1),
        .fwd_m2        (fwd_m2),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic check_wb(input string name, input wb_s exp, input wb_s act);
        if (act !== exp) begin
            errors++;
            $display(
                "FAILED %s: expected pc=%h x%0d we=%b val=%h, actual pc=%h x%0d we=%b val=%h",
                name, exp.pc, exp.rd_idx, exp.rd_we, exp.rd_val,
                act.pc, act.rd_idx, act.rd_we, act.rd_val);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_s exp, input fwd_s act);
        fwd_s cmp;
        cmp = act;
        if (!exp.val_avail) begin
            cmp.val = exp.val;   // value not final yet
        end
        if (cmp !== exp) begin
            errors++;
            $display(
                "FAILED %s: expected we=%b x%0d val=%h avail=%b, actual we=%b x%0d val=%h avail=%b",
                name, exp.rd_we, exp.rd_idx, exp.val, exp.val_avail,
                act.rd_we, act.rd_idx, act.val, act.val_avail);
        end
    endtask

    task automatic check_branch(input string name, input logic exp_taken, input word_t exp_target,
                                input logic act_taken, input word_t act_target);
        if (act_taken !== exp_taken || (exp_taken && act_target !== exp_target)) begin
            errors++;
            $display("FAILED %s: expected taken=%b target=%h, actual taken=%b target=%h",
                     name, exp_taken, exp_target, act_taken, act_target);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic close_run();
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // sampled on the falling edge, outputs are settled there
    task automatic wait_wb(input string name, input word_t pc);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(wb_valid === 1'b1 && wb.pc === pc) && cycles < WAIT_LIMIT);
        if (!(wb_valid === 1'b1 && wb.pc === pc)) begin
            errors++;
            $display("ERROR: %s got no writeback for pc %h within %0d cycles",
                     name, pc, WAIT_LIMIT);
            close_run();
        end
    endtask

    task automatic expect_no_wb(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag(name, 1'b0, wb_valid);
        end
    endtask

    task automatic send_item(input e_to_m1_s it);
        @(posedge clk);
        e_to_m1_valid <= 1'b1;
        e_to_m1       <= it;
    endtask

    task automatic idle_input();
        @(posedge clk);
        e_to_m1_valid <= 1'b0;
    endtask

    `include "mem_pipe_tests.svh"

    initial begin
        void'($urandom(29));
        errors        = 0;
        rst_n         = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        e_to_m1_valid = 1'b0;
        e_to_m1       = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_alu_csr_wb();
        test_store_load();
        test_store_load_bypass();
        test_stall_flush();
        test_branch_fwd();

        repeat (2) @(posedge clk);
        close_run();
    end

endmodule

/* vlog.f */
+incdir+tb
design/core_mem_pkg.sv
design/dmem_if.sv
design/stage_memory1.sv
design/stage_memory2.sv
design/data_mem.sv
design/mem_pipe_top.sv
tb/tb_mem_pipe.sv
